// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file sizes
`define CPU_WIDTH    32
`define CPU_REGS     8
`define CPU_SEL_BITS 3

// instruction word fields
`define OP_LSB       0
`define OP_MSB       5
`define SRC_A_LSB    6
`define SRC_B_LSB    9
`define DEST_LSB     12
`define HIGHLOW_BIT  15
`define IMM_LSB      16
`define IMM_BITS     16

`endif

// File: logic/cpu_pkg.sv
package cpu_pkg;

    // store is encoded as 7 and loadi as 8
    typedef enum logic [5:0] {
        op_nop       = 6'd0,
        op_add       = 6'd1,
        op_sub       = 6'd2,
        op_and       = 6'd3,
        op_or        = 6'd4,
        op_xor       = 6'd5,
        op_slt       = 6'd6,
        op_loadi     = 6'd8,
        op_store     = 6'd7,
        op_jump_flag = 6'd9,
        op_jump      = 6'd10,
        op_halt      = 6'd11
    } opcode_t;

    typedef enum logic [1:0] {
        st_fetch   = 2'd0,
        st_execute = 2'd1,
        st_halted  = 2'd2
    } cpu_state_t;

endpackage

// File: logic/control_fsm.sv
module control_fsm
    import cpu_pkg::*;
(
    input  logic       clock,
    input  logic       clear,
    input  opcode_t    opcode,
    input  logic       flag_a,
    output cpu_state_t state,
    output logic       reg_write,
    output logic       mem_write,
    output logic       pc_step,
    output logic       pc_jump,
    output logic       halted
);

    cpu_state_t state_next;
    logic       is_execute;
    logic       take_jump;

    always_comb
    begin
        case (state)
            st_fetch:   state_next = st_execute;
            st_execute: state_next = (opcode == op_halt) ? st_halted : st_fetch;
            default:    state_next = st_halted;
        endcase
    end

    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
            state <= st_fetch;
        else
            state <= state_next;
    end

    // halted follows the state register by one cycle
    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
            halted <= 1'b0;
        else
            halted <= (state == st_halted);
    end

    assign is_execute = (state == st_execute);
    assign take_jump  = (opcode == op_jump) || ((opcode == op_jump_flag) && flag_a);

    always_comb
    begin
        reg_write = 1'b0;
        mem_write = 1'b0;
        pc_step   = 1'b0;
        pc_jump   = 1'b0;
        if (is_execute)
        begin
            case (opcode)
                op_add, op_sub, op_and, op_or, op_xor, op_slt, op_loadi:
                    reg_write = 1'b1;
                op_store:
                    mem_write = 1'b1;
                default:
                    ;
            endcase
            pc_jump = take_jump;
            pc_step = !take_jump;
        end
    end

    // store strobe only in the execute cycle
    assert property (@(posedge clock) disable iff (clear)
        mem_write |-> state == st_execute);

    assert property (@(posedge clock) disable iff (clear)
        !(pc_step && pc_jump));

endmodule

// File: logic/program_counter.sv
`include "cpu_consts.svh"

module program_counter
(
    input  logic                  clock,
    input  logic                  clear,
    input  logic                  pc_step,
    input  logic                  pc_jump,
    input  logic [`IMM_BITS-1:0]  target,
    output logic [`CPU_WIDTH-1:0] pc
);

    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
            pc <= '0;
        else if (pc_jump)
            pc <= {{(`CPU_WIDTH - `IMM_BITS){1'b0}}, target};
        else if (pc_step)
            pc <= pc + 1'b1;
    end

    // the fsm holds both strobes low outside execute, so fetch must not move pc
    assert property (@(posedge clock) disable iff (clear)
        (!pc_step && !pc_jump) |=> $stable(pc));

endmodule

// File: logic/register_file.sv
`include "cpu_consts.svh"

module register_file
(
    input  logic                     clock,
    input  logic                     clear,
    input  logic [`CPU_SEL_BITS-1:0] sel_a,
    input  logic [`CPU_SEL_BITS-1:0] sel_b,
    input  logic [`CPU_SEL_BITS-1:0] sel_dest,
    input  logic                     write,
    input  logic [`CPU_WIDTH-1:0]    write_data,
    input  logic                     write_flag,
    output logic [`CPU_WIDTH-1:0]    reg_a,
    output logic [`CPU_WIDTH-1:0]    reg_b,
    output logic                     flag_a
);

    logic [`CPU_WIDTH-1:0] regs [`CPU_REGS];
    logic [`CPU_REGS-1:0]  flags;

    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
        begin
            for (int i = 0; i < `CPU_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (write)
        begin
            regs[sel_dest]  <= write_data;
            flags[sel_dest] <= write_flag;
        end
    end

    // combinational reads
    assign reg_a  = regs[sel_a];
    assign reg_b  = regs[sel_b];
    assign flag_a = flags[sel_a];

    assert property (@(posedge clock) disable iff (clear)
        write |-> !$isunknown(sel_dest));

endmodule

// File: logic/alu.sv
`include "cpu_consts.svh"

module alu
    import cpu_pkg::*;
(
    input  opcode_t               opcode,
    input  logic [`CPU_WIDTH-1:0] operand_a,
    input  logic [`CPU_WIDTH-1:0] operand_b,
    input  logic [`IMM_BITS-1:0]  immediate,
    input  logic                  highlow,
    output logic [`CPU_WIDTH-1:0] result,
    output logic                  result_flag
);

    logic                  less;
    logic [`CPU_WIDTH-1:0] imm_word;

    // unsigned compare
    assign less = (operand_a < operand_b);

    // high half keeps the low half of source a
    assign imm_word = highlow ?
        {immediate, operand_a[`CPU_WIDTH-`IMM_BITS-1:0]} :
        {{(`CPU_WIDTH - `IMM_BITS){1'b0}}, immediate};

    always_comb
    begin
        case (opcode)
            op_add:   result = operand_a + operand_b;
            op_sub:   result = operand_a - operand_b;
            op_and:   result = operand_a & operand_b;
            op_or:    result = operand_a | operand_b;
            op_xor:   result = operand_a ^ operand_b;
            op_slt:   result = {{(`CPU_WIDTH - 1){1'b0}}, less};
            op_loadi: result = imm_word;
            default:  result = '0;
        endcase
    end

    always_comb
    begin
        case (opcode)
            op_slt:
                result_flag = less;
            op_add, op_sub, op_and, op_or, op_xor, op_loadi:
                result_flag = (result == '0);
            default:
                result_flag = 1'b0;
        endcase
    end

endmodule

// File: logic/cpu_top.sv
`include "cpu_consts.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                  clock,
    input  logic                  clear,
    input  logic [`CPU_WIDTH-1:0] read_data,
    output logic [`CPU_WIDTH-1:0] address,
    output logic [`CPU_WIDTH-1:0] write_data,
    output logic                  mem_write,
    output logic                  halted
);

    logic [`CPU_WIDTH-1:0]    instr;
    opcode_t                  opcode;
    logic [`CPU_SEL_BITS-1:0] sel_a;
    logic [`CPU_SEL_BITS-1:0] sel_b;
    logic [`CPU_SEL_BITS-1:0] sel_dest;
    logic                     highlow;
    logic [`IMM_BITS-1:0]     immediate;

    cpu_state_t            state;
    logic                  reg_write;
    logic                  pc_step;
    logic                  pc_jump;
    logic [`CPU_WIDTH-1:0] pc;
    logic [`CPU_WIDTH-1:0] reg_a;
    logic [`CPU_WIDTH-1:0] reg_b;
    logic                  flag_a;
    logic [`CPU_WIDTH-1:0] result;
    logic                  result_flag;

    // instruction register loads on the fetch edge
    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
            instr <= '0;
        else if (state == st_fetch)
            instr <= read_data;
    end

    assign opcode    = opcode_t'(instr[`OP_MSB:`OP_LSB]);
    assign sel_a     = instr[`SRC_A_LSB +: `CPU_SEL_BITS];
    assign sel_b     = instr[`SRC_B_LSB +: `CPU_SEL_BITS];
    assign sel_dest  = instr[`DEST_LSB +: `CPU_SEL_BITS];
    assign highlow   = instr[`HIGHLOW_BIT];
    assign immediate = instr[`IMM_LSB +: `IMM_BITS];

    // stores address memory through source b
    assign address    = (state == st_execute) ? reg_b : pc;
    assign write_data = reg_a;

    control_fsm u_fsm (
        .clock     (clock),
        .clear     (clear),
        .opcode    (opcode),
        .flag_a    (flag_a),
        .state     (state),
        .reg_write (reg_write),
        .mem_write (mem_write),
        .pc_step   (pc_step),
        .pc_jump   (pc_jump),
        .halted    (halted)
    );

    program_counter u_pc (
        .clock   (clock),
        .clear   (clear),
        .pc_step (pc_step),
        .pc_jump (pc_jump),
        .target  (immediate),
        .pc      (pc)
    );

    register_file u_regs (
        .clock      (clock),
        .clear      (clear),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .sel_dest   (sel_dest),
        .write      (reg_write),
        .write_data (result),
        .write_flag (result_flag),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .flag_a     (flag_a)
    );

    alu u_alu (
        .opcode      (opcode),
        .operand_a   (reg_a),
        .operand_b   (reg_b),
        .immediate   (immediate),
        .highlow     (highlow),
        .result      (result),
        .result_flag (result_flag)
    );

endmodule

// File: sim/clock_gen.sv
module clock_gen
(
    output logic clock,
    output logic clear
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial
    begin
        clear = 1'b1;
        repeat (10) @(posedge clock);
        clear <= 1'b0;
    end

endmodule

// File: sim/store_checker.sv
`include "cpu_consts.svh"

module store_checker
(
    input  logic                  clock,
    input  logic                  clear,
    input  logic [`CPU_WIDTH-1:0] address,
    input  logic [`CPU_WIDTH-1:0] write_data,
    input  logic                  mem_write,
    input  logic                  halted,
    output logic                  done,
    output logic                  failed
);

    timeunit 1ns;
    timeprecision 1ps;

    string                 exp_name [$];
    logic [`CPU_WIDTH-1:0] exp_addr [$];
    logic [`CPU_WIDTH-1:0] exp_value [$];
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    next_store = 0;
    logic                  reset_bad = 1'b0;
    logic [`CPU_WIDTH+1:0] reset_seen = '0;

    initial
    begin
        done   = 1'b0;
        failed = 1'b0;
    end

    task automatic expect_store(input string name, input logic [`CPU_WIDTH-1:0] addr,
                                input logic [`CPU_WIDTH-1:0] value);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_value.push_back(value);
    endtask

    task automatic compare_store();
        if (next_store >= exp_name.size())
        begin
            $display("unexpected store of %h to address %h after the last expected store",
                     write_data, address);
            fail_count++;
        end
        else
        begin
            if (address !== exp_addr[next_store] || write_data !== exp_value[next_store])
            begin
                $display("Error %s: expected %h at %h, actual %h at %h", exp_name[next_store],
                         exp_value[next_store], exp_addr[next_store], write_data, address);
                fail_count++;
            end
            else
            begin
                $display("pass %s: %h at %h", exp_name[next_store], write_data, address);
                pass_count++;
            end
            next_store++;
        end
    endtask

    // while clear is high the memory port must sit idle at address 0
    always @(negedge clock)
    begin
        if (clear && !reset_bad && (mem_write !== 1'b0 || halted !== 1'b0 || address !== '0))
        begin
            reset_bad  = 1'b1;
            reset_seen = {mem_write, halted, address};
        end
    end

    always @(negedge clear)
    begin
        if (reset_bad)
        begin
            $display("Error reset: expected mem_write/halted/address 0/0/%h, actual %b/%b/%h",
                     {`CPU_WIDTH{1'b0}}, reset_seen[`CPU_WIDTH+1], reset_seen[`CPU_WIDTH],
                     reset_seen[`CPU_WIDTH-1:0]);
            fail_count++;
        end
        else
        begin
            $display("pass reset: port idle at address 0");
            pass_count++;
        end
    end

    always @(negedge clock)
    begin
        if (!clear && mem_write === 1'b1 && !done)
            compare_store();
    end

    initial
    begin
        wait (clear === 1'b0);
        wait (halted === 1'b1);
        // a stray store after the halt would still show up here
        repeat (4) @(negedge clock);
        if (next_store < exp_name.size())
        begin
            $display("halted with %0d expected stores never seen, first missing is %s",
                     exp_name.size() - next_store, exp_name[next_store]);
            fail_count++;
        end
        else
        begin
            $display("pass halt: all %0d stores seen before halted", exp_name.size());
            pass_count++;
        end
        $display("%0d passed, %0d failed", pass_count, fail_count);
        failed = (fail_count != 0);
        done   = 1'b1;
    end

endmodule

// File: sim/cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_BITS = 10;
    localparam int MEM_WORDS = 2 ** ADDR_BITS;

    logic                  clock;
    logic                  clear;
    logic [`CPU_WIDTH-1:0] read_data;
    logic [`CPU_WIDTH-1:0] address;
    logic [`CPU_WIDTH-1:0] write_data;
    logic                  mem_write;
    logic                  halted;
    logic                  done;
    logic                  failed;

    logic [`CPU_WIDTH-1:0] mem [MEM_WORDS];
    int                    instr_count;
    int                    store_count;
    logic                  loaded;
    logic                  load_ok;

    clock_gen clocks (
        .clock (clock),
        .clear (clear)
    );

    cpu_top uut (
        .clock      (clock),
        .clear      (clear),
        .read_data  (read_data),
        .address    (address),
        .write_data (write_data),
        .mem_write  (mem_write),
        .halted     (halted)
    );

    store_checker check_stores (
        .clock      (clock),
        .clear      (clear),
        .address    (address),
        .write_data (write_data),
        .mem_write  (mem_write),
        .halted     (halted),
        .done       (done),
        .failed     (failed)
    );

    // memory reads combinationally and writes on the rising edge
    assign read_data = mem[address[ADDR_BITS-1:0]];

    always @(posedge clock)
    begin
        if (mem_write)
            mem[address[ADDR_BITS-1:0]] <= write_data;
    end

    // unused words halt and carry their address in the immediate field
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] <= (i << 16) | 32'(op_halt);
        end
    endtask

    task automatic load_cases();
        int                    fd;
        int                    n;
        string                 tag;
        string                 name;
        string                 rest;
        logic [`CPU_WIDTH-1:0] addr;
        logic [`CPU_WIDTH-1:0] word;
        fd = $fopen("sim/program_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open sim/program_cases.txt");
            load_ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            if (tag == "I")
            begin
                n = $fscanf(fd, "%h %h", addr, word);
                if (n != 2)
                    load_ok = 1'b0;
                mem[addr[ADDR_BITS-1:0]] <= word;
                instr_count++;
            end
            else if (tag == "E")
            begin
                n = $fscanf(fd, "%s %h %h", name, addr, word);
                if (n != 3)
                    load_ok = 1'b0;
                check_stores.expect_store(name, addr, word);
                store_count++;
            end
            else
                n = $fgets(rest, fd);
        end
        $fclose(fd);
        if (!load_ok)
            $display("a line in sim/program_cases.txt could not be read");
    endtask

    initial
    begin
        loaded      = 1'b0;
        load_ok     = 1'b1;
        instr_count = 0;
        store_count = 0;
        fill_memory();
        load_cases();
        loaded = 1'b1;
        if (load_ok)
            wait (done === 1'b1);
        if (load_ok && !failed)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (loaded === 1'b1);
        repeat ((instr_count + store_count) * 64) @(posedge clock);
        $display("program did not halt within %0d clock cycles",
                 (instr_count + store_count) * 64);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim/program_cases.txt
# I <word address hex> <instruction word hex>
# E <test name> <store address hex> <store value hex>, in program order
# operands r1=1234 r2=0f0f, store base r7=200, step r6=1
I 000 12341008
I 001 0f0f2008
I 002 02007008
I 003 00016008
I 004 00003441
I 005 00000ec7
I 006 00003442
I 007 00000ec7
I 008 00003443
I 009 00000ec7
I 00a 00003444
I 00b 00000ec7
I 00c 00003445
I 00d 00000ec7
I 00e 00003282
I 00f 00000ec7
E add 200 00002143
E sub 200 00000325
E and 200 00000204
E or 200 00001f3f
E xor 200 00001d3b
E sub_wrap 200 fffffcdb
# loadi low then high into r4
I 010 beef4008
I 011 deadc108
I 012 00000f07
E imm_high 200 deadbeef
# slt flag taken skips the store at 016, then not taken
I 013 00005286
I 014 00000f47
I 015 00170149
I 016 00000e47
I 017 00005446
I 018 001a0149
I 019 00000f47
E slt_true 200 00000001
E slt_false 200 00000000
# count r1 down from 3, leave on the zero flag
I 01a 00031008
I 01b 00001c42
I 01c 00000e47
I 01d 00007dc1
I 01e 00200049
I 01f 001b000a
E loop_2 200 00000002
E loop_1 201 00000001
E loop_0 202 00000000
# jump over one store, then halt before the last one
I 020 0022000a
I 021 00000e87
I 022 00000e87
I 023 0000000b
I 024 00000e87
E jump 203 00000f0f

// File: all.f
+incdir+logic
logic/cpu_pkg.sv
logic/control_fsm.sv
logic/program_counter.sv
logic/register_file.sv
logic/alu.sv
logic/cpu_top.sv
sim/clock_gen.sv
sim/store_checker.sv
sim/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f all.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
